// File: Makefile
VERILATOR ?= verilator
TOP       ?= ks10Cpu_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo '** FAIL **' >> $(LOG)
	cat $(LOG)
	! grep -qF '** FAIL **' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: flist.f
+incdir+logic
logic/ks10Pkg.sv
logic/intervalTimer.sv
logic/intrPriority.sv
logic/aprFlags.sv
logic/cpuControl.sv
logic/ks10Cpu.sv
verif/ks10Cpu_asserts.sv
verif/ks10Cpu_tb.sv

// File: logic/aprFlags.sv
// APR flag, enable and level registers with command decode and the console interrupt output
`timescale 1ns/1ps
`default_nettype none

`include "ks10_defines.svh"

module aprFlags import ks10Pkg::*; (
   input  wire logic                   clk,           // Clock
   input  wire logic                   arstN,         // Async reset, active low
   input  wire logic                   aprCmdValid,   // Command strobe
   input  wire aprCmd_t                aprCmd,        // Command word
   input  wire logic                   timerTick,     // Interval wrap
   input  wire logic                   ks10Intr,      // Console interrupt to KS10
   output logic [`KS10_INTR_LEVELS-1:0] aprIntr,      // One-hot request at APR level
   output logic                        cslIntr,       // KS10 interrupt to console
   output logic                        dismiss        // Dismiss pulse
);

   aprFlags_t  flagReg;      // APR flags
   aprFlags_t  enableReg;    // Interrupt enables
   intrLevel_t aprLevel;     // Programmed APR level
   aprFlags_t  cmdMask;      // Flag bits of the data field
   aprFlags_t  hwSet;        // Flags set by hardware
   aprFlags_t  flagNext;
   aprFlags_t  reqFlags;     // Enabled and set
   logic       loadEn;

   assign cmdMask = aprFlags_t'(aprCmd.data[$bits(aprFlags_t)-1:0]);
   assign loadEn  = aprCmdValid && (aprCmd.op == loadEnables);
   assign dismiss = aprCmdValid && (aprCmd.op == ks10Pkg::dismiss);

   ////////////////////////////////////////////////////////////
   // Flag update
   ////////////////////////////////////////////////////////////

   always_comb begin
      hwSet            = '0;
      hwSet.timerDone  = timerTick;
      hwSet.consoleReq = ks10Intr;       // Held while the console asserts it
      flagNext         = flagReg;
      if (aprCmdValid) begin
         case (aprCmd.op)
            setFlags: flagNext = flagReg | cmdMask;
            clrFlags: flagNext = flagReg & ~cmdMask;
            default:  flagNext = flagReg;
         endcase
      end
      flagNext = flagNext | hwSet;        // Hardware set over clear
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         flagReg   <= '0;
         enableReg <= '0;
         aprLevel  <= '0;
      end else begin
         flagReg <= flagNext;
         if (loadEn) begin
            enableReg <= cmdMask;
            aprLevel  <= aprCmd.level;
         end
      end
   end

   // Request at the APR level, console flag excluded
   always_comb begin
      reqFlags         = flagReg & enableReg;
      reqFlags.cslIntr = 1'b0;
      aprIntr          = '0;
      if ((|reqFlags) && (aprLevel != '0)) begin
         aprIntr[aprLevel - 3'd1] = 1'b1;
      end
   end

   assign cslIntr = flagReg.cslIntr;

endmodule

`default_nettype wire

// File: logic/cpuControl.sv
// Run/halt state from the console switches and interrupt acceptance with the current priority
`timescale 1ns/1ps
`default_nettype none

module cpuControl import ks10Pkg::*; (
   input  wire logic       clk,           // Clock
   input  wire logic       arstN,         // Async reset, active low
   input  wire cslSwitch_t cslSwitch,     // Console switch strobes
   input  wire logic       intrPending,   // Requested level preempts current
   input  wire intrLevel_t reqIntp,       // Requested level
   input  wire logic       dismiss,       // Dismiss strobe from APR
   output logic            cpuHalt,       // Halted
   output logic            cpuRun,        // Running
   output logic            intrAck,       // Acceptance pulse
   output intrLevel_t      intrLevel      // Current level
);

   intrLevel_t curIntp;      // Current interrupt priority
   logic       goStrobe;     // Any strobe that starts the CPU
   logic       accept;       // Take the pending request this cycle

   ////////////////////////////////////////////////////////////
   // Run/halt state
   ////////////////////////////////////////////////////////////

   assign goStrobe = cslSwitch.run | cslSwitch.cont | cslSwitch.exec;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         cpuHalt <= 1'b1;                 // Come up halted
      end else if (cslSwitch.halt) begin
         cpuHalt <= 1'b1;                 // Halt wins
      end else if (goStrobe) begin
         cpuHalt <= 1'b0;
      end
   end

   assign cpuRun = ~cpuHalt;

   ////////////////////////////////////////////////////////////
   // Interrupt acceptance
   ////////////////////////////////////////////////////////////

   // No acceptance while a halt lands or right after an ack
   assign accept = cpuRun & intrPending & ~cslSwitch.halt & ~intrAck;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         intrAck <= 1'b0;
         curIntp <= '0;
      end else begin
         intrAck <= accept;
         if (accept) begin
            curIntp <= reqIntp;           // Acceptance beats a dismiss
         end else if (dismiss) begin
            curIntp <= '0;                // No stacking, back to none
         end
      end
   end

   assign intrLevel = curIntp;            // Valid with the ack pulse

endmodule

`default_nettype wire

// File: logic/intervalTimer.sv
// Prescaled millisecond counter, gated by the console enable and run state, pulses on interval wrap
`timescale 1ns/1ps
`default_nettype none

`include "ks10_defines.svh"

module intervalTimer (
   input  wire logic                    clk,          // Clock
   input  wire logic                    arstN,        // Async reset, active low
   input  wire logic                    cslTimerEn,   // Console timer enable
   input  wire logic                    cpuRun,       // CPU running
   output logic                         timerTick,    // Interval wrap pulse
   output logic [`KS10_TIMER_WIDTH-1:0] timerCount    // Millisecond count
);

   localparam int preWidth = ($clog2(`KS10_TIMER_PRESCALE) < 1) ?
                             1 : $clog2(`KS10_TIMER_PRESCALE);

   logic [preWidth-1:0] preCount;   // Prescaler
   logic                countEn;
   logic                preWrap;    // Last prescaler cycle

   assign countEn = cslTimerEn & cpuRun;
   assign preWrap = (preCount == preWidth'(`KS10_TIMER_PRESCALE - 1));

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         preCount   <= '0;
         timerCount <= '0;
         timerTick  <= 1'b0;
      end else if (countEn) begin
         preCount  <= preWrap ? '0 : preCount + 1'b1;
         timerTick <= 1'b0;
         if (preWrap) begin
            timerCount <= timerCount + 1'b1;
            // Low bits all ones roll over to zero here
            timerTick  <= &timerCount[`KS10_TIMER_INTERVAL_BITS-1:0];
         end
      end else begin
         timerTick <= 1'b0;                // Hold count while gated off
      end
   end

endmodule

`default_nettype wire

// File: logic/intrPriority.sv
// Combinational priority encoder over bus and APR requests against the current interrupt level
`timescale 1ns/1ps
`default_nettype none

`include "ks10_defines.svh"

module intrPriority import ks10Pkg::*; (
   input  wire logic [`KS10_INTR_LEVELS-1:0] busIntr,      // Unibus requests
   input  wire logic [`KS10_INTR_LEVELS-1:0] aprIntr,      // APR request
   input  wire intrLevel_t                   curIntp,      // Current level
   output intrLevel_t                        reqIntp,      // Highest requested level
   output logic                              intrPending   // Preempts current level
);

   logic [`KS10_INTR_LEVELS-1:0] allReq;   // Merged requests

   assign allReq = busIntr | aprIntr;

   // Scan down so the lowest-numbered level ends up in reqIntp
   always_comb begin
      reqIntp = '0;
      for (int k = `KS10_INTR_LEVELS - 1; k >= 0; k--) begin
         if (allReq[k]) begin
            reqIntp = intrLevel_t'(k + 1);
         end
      end
   end

   // Lower number is higher priority
   assign intrPending = (reqIntp != '0) &&
                        ((curIntp == '0) || (reqIntp < curIntp));

endmodule

`default_nettype wire

// File: logic/ks10Cpu.sv
// Top of the KS10 interrupt shell, connects run/halt control, APR flags, timer and priority logic
`timescale 1ns/1ps
`default_nettype none

`include "ks10_defines.svh"

module ks10Cpu import ks10Pkg::*; (
   input  wire logic                         clk,          // Clock
   input  wire logic                         arstN,        // Async reset, active low
   input  wire cslSwitch_t                   cslSwitch,    // Console switch strobes
   input  wire logic                         cslTimerEn,   // Console timer enable
   input  wire logic                         ks10Intr,     // Console interrupt to KS10
   input  wire logic [`KS10_INTR_LEVELS-1:0] busIntr,      // Unibus requests, bit k is level k+1
   input  wire logic                         aprCmdValid,  // Command strobe
   input  wire aprCmd_t                      aprCmd,       // Command word
   output logic                              cslIntr,      // KS10 interrupt to console
   output logic                              cpuHalt,      // Run/halt status
   output logic                              intrAck,      // Interrupt accepted
   output intrLevel_t                        intrLevel,    // Current interrupt level
   output logic [`KS10_TIMER_WIDTH-1:0]      timerCount    // Millisecond count
);

   logic                         cpuRun;        // Timer gate
   logic [`KS10_INTR_LEVELS-1:0] aprIntr;       // One-hot APR request
   intrLevel_t                   reqIntp;       // Highest requested level
   logic                         intrPending;   // Request preempts current level
   logic                         timerTick;     // Interval wrap
   logic                         dismiss;       // Return to no interrupt

   ////////////////////////////////////////////////////////////
   // Control and datapath
   ////////////////////////////////////////////////////////////

   cpuControl cpuControl_inst (
      .clk         (clk),
      .arstN       (arstN),
      .cslSwitch   (cslSwitch),
      .intrPending (intrPending),
      .reqIntp     (reqIntp),
      .dismiss     (dismiss),
      .cpuHalt     (cpuHalt),
      .cpuRun      (cpuRun),
      .intrAck     (intrAck),
      .intrLevel   (intrLevel)
   );

   aprFlags aprFlags_inst (
      .clk         (clk),
      .arstN       (arstN),
      .aprCmdValid (aprCmdValid),
      .aprCmd      (aprCmd),
      .timerTick   (timerTick),
      .ks10Intr    (ks10Intr),
      .aprIntr     (aprIntr),
      .cslIntr     (cslIntr),
      .dismiss     (dismiss)
   );

   intervalTimer intervalTimer_inst (
      .clk         (clk),
      .arstN       (arstN),
      .cslTimerEn  (cslTimerEn),
      .cpuRun      (cpuRun),
      .timerTick   (timerTick),
      .timerCount  (timerCount)
   );

   // intrLevel is the current priority register
   intrPriority intrPriority_inst (
      .busIntr     (busIntr),
      .aprIntr     (aprIntr),
      .curIntp     (intrLevel),
      .reqIntp     (reqIntp),
      .intrPending (intrPending)
   );

endmodule

`default_nettype wire

// File: logic/ks10Pkg.sv
// Shared types of the KS10 interrupt shell, imported by the RTL modules and the testbench
`default_nettype none

`include "ks10_defines.svh"

package ks10Pkg;

   // Priority level, 0 means no interrupt
   typedef logic [2:0] intrLevel_t;

   // APR flag bits, cslIntr is the MSB
   typedef struct packed {
      logic cslIntr;      // KS10 interrupt to console
      logic pwrFail;      // Power fail
      logic nxm;          // Nonexistent memory
      logic badData;      // Uncorrectable memory data
      logic corData;      // Corrected memory data
      logic timerDone;    // Interval timer wrapped
      logic consoleReq;   // Console interrupt to KS10
   } aprFlags_t;

   // APR command opcodes
   typedef enum logic [1:0] {
      setFlags,
      clrFlags,
      loadEnables,
      dismiss
   } aprOp_t;

   // Command word, 13 bits
   typedef struct packed {
      aprOp_t                          op;
      logic [`KS10_APR_DATA_WIDTH-1:0] data;    // Flag or enable bits
      intrLevel_t                      level;   // APR level for loadEnables
   } aprCmd_t;

   // Console switch strobes
   typedef struct packed {
      logic run;
      logic cont;
      logic exec;
      logic halt;
   } cslSwitch_t;

endpackage

`default_nettype wire

// File: logic/ks10_defines.svh
// Widths and constants for the KS10 interrupt shell, included by RTL and testbench alike
`ifndef KS10_DEFINES_SVH
`define KS10_DEFINES_SVH

////////////////////////////////////////////////////////////
// Interrupt priority
////////////////////////////////////////////////////////////

`define KS10_INTR_LEVELS 7            // Levels 1..7, level 1 highest, 0 is none

////////////////////////////////////////////////////////////
// Interval timer
////////////////////////////////////////////////////////////

`define KS10_TIMER_WIDTH 18           // Millisecond count width
`define KS10_TIMER_PRESCALE 4         // Clocks per tick, small for simulation
`define KS10_TIMER_INTERVAL_BITS 4    // Low count bits, flag every 16 ticks

// APR command data field
`define KS10_APR_DATA_WIDTH 8

`endif

// File: verif/ks10Cpu_asserts.sv
// Concurrent checks on the acknowledge outputs of cpuControl, attached by bind
`timescale 1ns/1ps
`default_nettype none

module ks10Cpu_asserts import ks10Pkg::*; (
   input wire logic       clk,
   input wire logic       arstN,
   input wire logic       intrAck,
   input wire logic       cpuHalt,
   input wire intrLevel_t intrLevel
);

   ackIsPulse: assert property (@(posedge clk) disable iff (!arstN) intrAck |=> !intrAck)
      else $error("intrAck held high for two cycles");

   noAckHalted: assert property (@(posedge clk) disable iff (!arstN) !(intrAck && cpuHalt))
      else $error("intrAck high while halted");

   ackLevelSet: assert property (@(posedge clk) disable iff (!arstN) intrAck |-> (intrLevel != '0))
      else $error("intrAck with level zero");

endmodule

bind cpuControl ks10Cpu_asserts ks10Cpu_asserts_inst (
   .clk(clk), .arstN(arstN), .intrAck(intrAck), .cpuHalt(cpuHalt), .intrLevel(intrLevel)
);

`default_nettype wire

// File: verif/ks10Cpu_tb.sv
// Testbench for the KS10 interrupt shell, drives console, commands and bus requests against a model
`timescale 1ns/1ps
`default_nettype none

`include "ks10_defines.svh"

module ks10Cpu_tb import ks10Pkg::*; ();

   logic clk = 1'b0;
   logic arstN, cslTimerEn, ks10Intr, aprCmdValid, cslIntr, cpuHalt, intrAck;
   cslSwitch_t cslSwitch;
   aprCmd_t aprCmd;
   logic [`KS10_INTR_LEVELS-1:0] busIntr;
   intrLevel_t intrLevel;
   logic [`KS10_TIMER_WIDTH-1:0] timerCount;
   int checks = 0, errors = 0, timeouts = 0;
   // Model state
   logic mHalt, mAck, mTick;
   intrLevel_t mCur, mAprLvl;
   aprFlags_t mFlags, mEn;
   int mPre;
   logic [`KS10_TIMER_WIDTH-1:0] mCount;

   ks10Cpu ks10Cpu_inst (.*);

   always #50 clk = ~clk;                 // 100 ns period

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Level to acknowledge next, 0 when nothing preempts cur
   function automatic intrLevel_t expectLevel(input logic [`KS10_INTR_LEVELS-1:0] bus,
      input aprFlags_t flags, input aprFlags_t en, input intrLevel_t aprLvl, input intrLevel_t cur);
      aprFlags_t active;
      intrLevel_t best, lv;
      active = flags & en;
      active.cslIntr = 1'b0;              // Console flag never interrupts
      best = '0;
      lv = intrLevel_t'(`KS10_INTR_LEVELS);
      while (lv != 3'd0) begin            // Walk down, lowest number wins
         if (bus[lv - 3'd1] || ((|active) && (aprLvl == lv)))
            best = lv;
         lv = lv - 3'd1;
      end
      return ((best != '0) && ((cur == '0) || (best < cur))) ? best : intrLevel_t'(0);
   endfunction

   task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic nextCycle();
      @(posedge clk);
      #5;                                 // Drive after the edge
   endtask

   task automatic strobeSwitch(input cslSwitch_t sw);
      cslSwitch = sw;
      nextCycle();
      cslSwitch = '0;
   endtask

   task automatic sendCmd(input aprOp_t op, input logic [7:0] data, input intrLevel_t lvl);
      aprCmdValid = 1'b1;
      aprCmd.op = op;
      aprCmd.data = data;
      aprCmd.level = lvl;
      nextCycle();
      aprCmdValid = 1'b0;
   endtask

   task automatic waitAck(input int maxCycles, input string what);
      int n;
      n = 0;
      nextCycle();
      while (!intrAck && (n < maxCycles)) begin
         nextCycle();
         n++;
      end
      if (!intrAck) begin
         timeouts++;
         $display("Timeout: no interrupt acknowledge arrived for %s", what);
      end
   endtask

   task automatic holdNoAck(input int cycles, input string name);
      int acks;
      acks = 0;
      repeat (cycles) begin
         nextCycle();
         acks += int'(intrAck);
      end
      checkEq(name, 32'(acks), 32'd0);
   endtask

   ////////////////////////////////////////////////////////////
   // Cycle model and compare on the falling edge
   ////////////////////////////////////////////////////////////

   always @(negedge clk) begin : compareModel
      intrLevel_t lvl;
      logic accept;
      if (!arstN) begin
         {mHalt, mAck, mTick, mCur, mAprLvl, mFlags, mEn, mPre, mCount} = '0;
         mHalt = 1'b1;
      end else begin
         checkEq("cpuHalt", 32'(cpuHalt), 32'(mHalt));
         checkEq("intrAck", 32'(intrAck), 32'(mAck));
         checkEq("intrLevel", 32'(intrLevel), 32'(mCur));
         checkEq("cslIntr", 32'(cslIntr), 32'(mFlags.cslIntr));
         checkEq("timerCount", 32'(timerCount), 32'(mCount));
         lvl = expectLevel(busIntr, mFlags, mEn, mAprLvl, mCur);
         accept = !mHalt && (lvl != '0) && !cslSwitch.halt && !mAck;
         mAck = accept;
         if (accept)
            mCur = lvl;
         else if (aprCmdValid && (aprCmd.op == dismiss))
            mCur = '0;
         if (aprCmdValid && (aprCmd.op == setFlags))
            mFlags = mFlags | aprFlags_t'(aprCmd.data[6:0]);
         if (aprCmdValid && (aprCmd.op == clrFlags))
            mFlags = mFlags & ~aprFlags_t'(aprCmd.data[6:0]);
         mFlags.timerDone  = mFlags.timerDone | mTick;     // Hardware set last
         mFlags.consoleReq = mFlags.consoleReq | ks10Intr;
         if (aprCmdValid && (aprCmd.op == loadEnables)) begin
            mEn = aprFlags_t'(aprCmd.data[6:0]);
            mAprLvl = aprCmd.level;
         end
         mTick = 1'b0;
         if (cslTimerEn && !mHalt) begin
            if (mPre == `KS10_TIMER_PRESCALE - 1) begin
               mTick = &mCount[`KS10_TIMER_INTERVAL_BITS-1:0];  // Interval wrap
               mCount = mCount + 1'b1;
               mPre = 0;
            end else begin
               mPre++;
            end
         end
         if (cslSwitch.halt)
            mHalt = 1'b1;
         else if (cslSwitch.run || cslSwitch.cont || cslSwitch.exec)
            mHalt = 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////

   initial begin
      logic [31:0] rng;
      logic [6:0] pattern;
      logic [`KS10_TIMER_WIDTH-1:0] startCount;
      rng = 32'd76324;
      {arstN, cslTimerEn, ks10Intr, aprCmdValid, cslSwitch, aprCmd, busIntr} = '0;
      repeat (2) @(posedge clk);
      #5 arstN = 1'b1;
      checkEq("cpuHalt", 32'(cpuHalt), 32'd1);
      checkEq("cslIntr", 32'(cslIntr), 32'd0);
      checkEq("intrAck", 32'(intrAck), 32'd0);
      strobeSwitch(cslSwitch_t'(4'b1000));          // Run
      checkEq("cpuHalt", 32'(cpuHalt), 32'd0);
      strobeSwitch(cslSwitch_t'(4'b0001));          // Halt
      checkEq("cpuHalt", 32'(cpuHalt), 32'd1);
      strobeSwitch(cslSwitch_t'(4'b0100));          // Continue
      // APR commands and console request
      sendCmd(setFlags, 8'h40, 3'd0);
      checkEq("cslIntr", 32'(cslIntr), 32'd1);
      sendCmd(clrFlags, 8'h40, 3'd0);
      checkEq("cslIntr", 32'(cslIntr), 32'd0);
      ks10Intr = 1'b1;
      nextCycle();
      ks10Intr = 1'b0;
      sendCmd(loadEnables, 8'h01, 3'd3);
      waitAck(8, "console request");
      checkEq("intrLevel", 32'(intrLevel), 32'd3);
      sendCmd(clrFlags, 8'h01, 3'd0);
      sendCmd(loadEnables, 8'h00, 3'd0);
      sendCmd(dismiss, 8'h00, 3'd0);
      // Random bus requests, held while current
      for (int i = 0; i < 16; i++) begin
         rng = xorshift(rng);
         pattern = (rng[6:0] == 7'd0) ? 7'h40 : rng[6:0];
         busIntr = pattern;
         waitAck(8, "random bus request");
         checkEq("intrLevel", 32'(intrLevel), 32'(expectLevel(pattern, '0, '0, '0, '0)));
         holdNoAck(6, "repeated intrAck");
         busIntr = '0;
         sendCmd(dismiss, 8'h00, 3'd0);
      end
      // Preemption of level 5 by level 2
      busIntr = 7'b0010000;
      waitAck(8, "level 5 request");
      checkEq("intrLevel", 32'(intrLevel), 32'd5);
      busIntr = 7'b0010010;
      waitAck(8, "preempting level 2 request");
      checkEq("intrLevel", 32'(intrLevel), 32'd2);
      busIntr = '0;
      sendCmd(dismiss, 8'h00, 3'd0);
      // Interval timer
      cslTimerEn = 1'b1;
      startCount = timerCount;
      repeat (4 * `KS10_TIMER_PRESCALE) nextCycle();
      checkEq("timerCount", 32'(timerCount), 32'(startCount) + 32'd4);
      busIntr = 7'b0000100;                         // Level 3 lands with the halt
      strobeSwitch(cslSwitch_t'(4'b0001));
      startCount = timerCount;
      holdNoAck(3 * `KS10_TIMER_PRESCALE, "intrAck while halted");
      checkEq("timerCount", 32'(timerCount), 32'(startCount));
      busIntr = '0;
      strobeSwitch(cslSwitch_t'(4'b0010));          // Execute
      sendCmd(clrFlags, 8'h02, 3'd0);
      sendCmd(loadEnables, 8'h02, 3'd6);
      waitAck(16 * `KS10_TIMER_PRESCALE + 16, "timer flag");
      checkEq("intrLevel", 32'(intrLevel), 32'd6);
      cslTimerEn = 1'b0;
      sendCmd(clrFlags, 8'h02, 3'd0);
      sendCmd(dismiss, 8'h00, 3'd0);
      repeat (4) nextCycle();
      $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
      if ((errors == 0) && (timeouts == 0))
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire
